// File: axi_to_mem.f
+incdir+rtl
rtl/axi_mem_pkg.sv
rtl/axi_read_burst.sv
rtl/axi_write_burst.sv
rtl/beat_arbiter.sv
rtl/mem_to_banks.sv
rtl/resp_tracker.sv
rtl/axi_to_mem.sv
testbench/bank_mem_model.sv
testbench/tb_axi_to_mem.sv

// File: rtl/axi_mem_pkg.sv
// Width types of the AXI to memory bridge
// Beat size and beat address step functions

`default_nettype none

`include "axi_mem_settings.svh"

package axi_mem_pkg;

  typedef logic [`AXI_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`AXI_DATA_WIDTH-1:0]   data_t;
  typedef logic [`AXI_DATA_WIDTH/8-1:0] strb_t;
  typedef logic [`AXI_ID_WIDTH-1:0]     id_t;
  typedef logic [`AXI_LEN_WIDTH-1:0]    len_t;

  // One bank's slice of a beat
  typedef logic [`AXI_DATA_WIDTH/`MEM_NUM_BANKS-1:0]   bank_data_t;
  typedef logic [`AXI_DATA_WIDTH/`MEM_NUM_BANKS/8-1:0] bank_strb_t;

  // Bytes per beat, always full width
  function automatic addr_t beat_bytes();
    return addr_t'(`AXI_DATA_WIDTH / 8);
  endfunction

  // Aligned address of the beat after addr
  function automatic addr_t next_beat_addr(input addr_t addr);
    addr_t mask;
    mask = ~(beat_bytes() - addr_t'(1));
    return (addr & mask) + beat_bytes();
  endfunction

endpackage

`default_nettype wire

// File: rtl/axi_mem_settings.svh
// Widths, bank count and response buffer depth of the AXI to memory bridge
// AXI burst type encoding

`ifndef AXI_MEM_SETTINGS_SVH
`define AXI_MEM_SETTINGS_SVH

// AXI side
`define AXI_ADDR_WIDTH 16
`define AXI_DATA_WIDTH 32
`define AXI_ID_WIDTH   4
`define AXI_LEN_WIDTH  8

// Memory side, banks must split the data into whole bytes
`define MEM_NUM_BANKS  2
`define RESP_BUF_DEPTH 2

`define AXI_BURST_INCR 2'b01

`endif

// File: rtl/axi_read_burst.sv
// Read burst unit
// Accepts AR and offers one beat request per read beat

`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_settings.svh"

module axi_read_burst
  import axi_mem_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       ar_valid_i,
  output logic       ar_ready_o,
  input  addr_t      ar_addr_i,
  input  id_t        ar_id_i,
  input  len_t       ar_len_i,
  input  logic [1:0] ar_burst_i,
  output logic       beat_valid_o,
  input  logic       beat_ready_i,
  output addr_t      beat_addr_o,
  output id_t        beat_id_o,
  output logic       beat_last_o,
  output logic       active_o
);

  logic  active_q;
  logic  ready_q;
  len_t  cnt_q;
  addr_t addr_q;
  id_t   id_q;
  logic  ar_hs;
  logic  beat_hs;

  assign ar_hs   = ar_valid_i & ready_q;
  assign beat_hs = active_q & beat_ready_i;

  assign ar_ready_o   = ready_q;
  assign beat_valid_o = active_q;
  assign beat_addr_o  = addr_q;
  assign beat_id_o    = id_q;
  assign beat_last_o  = (cnt_q == '0);
  assign active_o     = active_q;

  // cnt_q counts the beats left after the current one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      ready_q  <= 1'b0;
      cnt_q    <= '0;
    end else if (ar_hs) begin
      active_q <= 1'b1;
      ready_q  <= 1'b0;
      cnt_q    <= ar_len_i;
    end else if (beat_hs) begin
      if (beat_last_o) begin
        active_q <= 1'b0;
        ready_q  <= 1'b1;
      end else begin
        cnt_q <= cnt_q - len_t'(1);
      end
    end else begin
      ready_q <= ~active_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      addr_q <= ar_addr_i;
      id_q   <= ar_id_i;
    end else if (beat_hs) begin
      addr_q <= next_beat_addr(addr_q);
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_i && (ar_len_i != '0) |-> ar_burst_i == `AXI_BURST_INCR)
    else $error("Only INCR read bursts are supported");

endmodule

`default_nettype wire

// File: rtl/axi_to_mem.sv
// AXI4 subordinate to banked memory bridge, top level
// Burst units, beat arbiter, bank splitter and response tracker

`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_settings.svh"

module axi_to_mem
  import axi_mem_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_ni,
  output logic                            busy_o,
  input  logic                            aw_valid_i,
  output logic                            aw_ready_o,
  input  addr_t                           aw_addr_i,
  input  id_t                             aw_id_i,
  input  len_t                            aw_len_i,
  input  logic       [1:0]                aw_burst_i,
  input  logic                            w_valid_i,
  output logic                            w_ready_o,
  input  data_t                           w_data_i,
  input  strb_t                           w_strb_i,
  output logic                            b_valid_o,
  input  logic                            b_ready_i,
  output id_t                             b_id_o,
  input  logic                            ar_valid_i,
  output logic                            ar_ready_o,
  input  addr_t                           ar_addr_i,
  input  id_t                             ar_id_i,
  input  len_t                            ar_len_i,
  input  logic       [1:0]                ar_burst_i,
  output logic                            r_valid_o,
  input  logic                            r_ready_i,
  output data_t                           r_data_o,
  output id_t                             r_id_o,
  output logic                            r_last_o,
  output logic       [`MEM_NUM_BANKS-1:0] bank_req_o,
  input  logic       [`MEM_NUM_BANKS-1:0] bank_gnt_i,
  output addr_t      [`MEM_NUM_BANKS-1:0] bank_addr_o,
  output bank_data_t [`MEM_NUM_BANKS-1:0] bank_wdata_o,
  output bank_strb_t [`MEM_NUM_BANKS-1:0] bank_strb_o,
  output logic       [`MEM_NUM_BANKS-1:0] bank_we_o,
  input  logic       [`MEM_NUM_BANKS-1:0] bank_rvalid_i,
  input  bank_data_t [`MEM_NUM_BANKS-1:0] bank_rdata_i
);

  logic  rd_valid;
  logic  rd_ready;
  addr_t rd_addr;
  id_t   rd_id;
  logic  rd_last;
  logic  rd_active;
  logic  wr_valid;
  logic  wr_ready;
  addr_t wr_addr;
  id_t   wr_id;
  logic  wr_last;
  data_t wr_data;
  strb_t wr_strb;
  logic  wr_active;
  logic  mem_req;
  logic  mem_gnt;
  addr_t mem_addr;
  data_t mem_wdata;
  strb_t mem_strb;
  logic  mem_we;
  logic  mem_rvalid;
  logic  mem_rready;
  data_t mem_rdata;
  logic  track_valid;
  logic  track_ready;
  id_t   track_id;
  logic  track_last;
  logic  track_write;
  logic  idle;

  assign busy_o = aw_valid_i | w_valid_i | ar_valid_i | b_valid_o | r_valid_o |
                  rd_active | wr_active | ~idle;

  axi_read_burst i_read_burst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ar_valid_i   (ar_valid_i),
    .ar_ready_o   (ar_ready_o),
    .ar_addr_i    (ar_addr_i),
    .ar_id_i      (ar_id_i),
    .ar_len_i     (ar_len_i),
    .ar_burst_i   (ar_burst_i),
    .beat_valid_o (rd_valid),
    .beat_ready_i (rd_ready),
    .beat_addr_o  (rd_addr),
    .beat_id_o    (rd_id),
    .beat_last_o  (rd_last),
    .active_o     (rd_active)
  );

  axi_write_burst i_write_burst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .aw_valid_i   (aw_valid_i),
    .aw_ready_o   (aw_ready_o),
    .aw_addr_i    (aw_addr_i),
    .aw_id_i      (aw_id_i),
    .aw_len_i     (aw_len_i),
    .aw_burst_i   (aw_burst_i),
    .w_valid_i    (w_valid_i),
    .w_ready_o    (w_ready_o),
    .w_data_i     (w_data_i),
    .w_strb_i     (w_strb_i),
    .beat_valid_o (wr_valid),
    .beat_ready_i (wr_ready),
    .beat_addr_o  (wr_addr),
    .beat_id_o    (wr_id),
    .beat_last_o  (wr_last),
    .beat_data_o  (wr_data),
    .beat_strb_o  (wr_strb),
    .active_o     (wr_active)
  );

  beat_arbiter i_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_valid_i    (rd_valid),
    .rd_ready_o    (rd_ready),
    .rd_addr_i     (rd_addr),
    .rd_id_i       (rd_id),
    .rd_last_i     (rd_last),
    .rd_active_i   (rd_active),
    .wr_valid_i    (wr_valid),
    .wr_ready_o    (wr_ready),
    .wr_addr_i     (wr_addr),
    .wr_id_i       (wr_id),
    .wr_last_i     (wr_last),
    .wr_data_i     (wr_data),
    .wr_strb_i     (wr_strb),
    .wr_active_i   (wr_active),
    .mem_req_o     (mem_req),
    .mem_gnt_i     (mem_gnt),
    .mem_addr_o    (mem_addr),
    .mem_wdata_o   (mem_wdata),
    .mem_strb_o    (mem_strb),
    .mem_we_o      (mem_we),
    .track_valid_o (track_valid),
    .track_ready_i (track_ready),
    .track_id_o    (track_id),
    .track_last_o  (track_last),
    .track_write_o (track_write)
  );

  mem_to_banks i_mem_to_banks (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (mem_req),
    .gnt_o         (mem_gnt),
    .addr_i        (mem_addr),
    .wdata_i       (mem_wdata),
    .strb_i        (mem_strb),
    .we_i          (mem_we),
    .rvalid_o      (mem_rvalid),
    .rready_i      (mem_rready),
    .rdata_o       (mem_rdata),
    .bank_req_o    (bank_req_o),
    .bank_gnt_i    (bank_gnt_i),
    .bank_addr_o   (bank_addr_o),
    .bank_wdata_o  (bank_wdata_o),
    .bank_strb_o   (bank_strb_o),
    .bank_we_o     (bank_we_o),
    .bank_rvalid_i (bank_rvalid_i),
    .bank_rdata_i  (bank_rdata_i)
  );

  resp_tracker i_resp_tracker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .track_valid_i (track_valid),
    .track_ready_o (track_ready),
    .track_id_i    (track_id),
    .track_last_i  (track_last),
    .track_write_i (track_write),
    .mem_rvalid_i  (mem_rvalid),
    .mem_rready_o  (mem_rready),
    .mem_rdata_i   (mem_rdata),
    .r_valid_o     (r_valid_o),
    .r_ready_i     (r_ready_i),
    .r_data_o      (r_data_o),
    .r_id_o        (r_id_o),
    .r_last_o      (r_last_o),
    .b_valid_o     (b_valid_o),
    .b_ready_i     (b_ready_i),
    .b_id_o        (b_id_o),
    .idle_o        (idle)
  );

endmodule

`default_nettype wire

// File: rtl/axi_write_burst.sv
// Write burst unit
// Registers AW and pairs every W beat with its address and last flag

`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_settings.svh"

module axi_write_burst
  import axi_mem_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       aw_valid_i,
  output logic       aw_ready_o,
  input  addr_t      aw_addr_i,
  input  id_t        aw_id_i,
  input  len_t       aw_len_i,
  input  logic [1:0] aw_burst_i,
  input  logic       w_valid_i,
  output logic       w_ready_o,
  input  data_t      w_data_i,
  input  strb_t      w_strb_i,
  output logic       beat_valid_o,
  input  logic       beat_ready_i,
  output addr_t      beat_addr_o,
  output id_t        beat_id_o,
  output logic       beat_last_o,
  output data_t      beat_data_o,
  output strb_t      beat_strb_o,
  output logic       active_o
);

  logic  active_q;
  logic  ready_q;
  len_t  cnt_q;
  addr_t addr_q;
  id_t   id_q;
  logic  aw_hs;
  logic  beat_hs;

  assign aw_hs   = aw_valid_i & ready_q;
  assign beat_hs = active_q & w_valid_i & beat_ready_i;

  assign aw_ready_o = ready_q;
  assign active_o   = active_q;

  // W passes straight through once the burst is open
  assign beat_valid_o = active_q & w_valid_i;
  assign w_ready_o    = active_q & beat_ready_i;
  assign beat_data_o  = w_data_i;
  assign beat_strb_o  = w_strb_i;
  assign beat_addr_o  = addr_q;
  assign beat_id_o    = id_q;
  assign beat_last_o  = (cnt_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      ready_q  <= 1'b0;
      cnt_q    <= '0;
    end else if (aw_hs) begin
      active_q <= 1'b1;
      ready_q  <= 1'b0;
      cnt_q    <= aw_len_i;
    end else if (beat_hs) begin
      if (beat_last_o) begin
        active_q <= 1'b0;
        ready_q  <= 1'b1;
      end else begin
        cnt_q <= cnt_q - len_t'(1);
      end
    end else begin
      ready_q <= ~active_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      addr_q <= aw_addr_i;
      id_q   <= aw_id_i;
    end else if (beat_hs) begin
      addr_q <= next_beat_addr(addr_q);
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_i && (aw_len_i != '0) |-> aw_burst_i == `AXI_BURST_INCR)
    else $error("Only INCR write bursts are supported");

endmodule

`default_nettype wire

// File: rtl/beat_arbiter.sv
// Read/write beat arbiter
// Selects one beat and hands it to the memory and the response tracker together

`timescale 1ns/1ps
`default_nettype none

module beat_arbiter
  import axi_mem_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  rd_valid_i,
  output logic  rd_ready_o,
  input  addr_t rd_addr_i,
  input  id_t   rd_id_i,
  input  logic  rd_last_i,
  input  logic  rd_active_i,
  input  logic  wr_valid_i,
  output logic  wr_ready_o,
  input  addr_t wr_addr_i,
  input  id_t   wr_id_i,
  input  logic  wr_last_i,
  input  data_t wr_data_i,
  input  strb_t wr_strb_i,
  input  logic  wr_active_i,
  output logic  mem_req_o,
  input  logic  mem_gnt_i,
  output addr_t mem_addr_o,
  output data_t mem_wdata_o,
  output strb_t mem_strb_o,
  output logic  mem_we_o,
  output logic  track_valid_o,
  input  logic  track_ready_i,
  output id_t   track_id_o,
  output logic  track_last_o,
  output logic  track_write_o
);

  // sel_q is the last choice, 1 for write
  logic sel_q;
  logic lock_q;
  logic cont_q;
  logic sel;
  logic win_valid;
  logic win_last;
  logic grant;

  always_comb begin
    sel = sel_q;
    if (!lock_q) begin
      if (wr_valid_i ^ rd_valid_i) begin
        sel = wr_valid_i;
      end else if (wr_valid_i && rd_valid_i) begin
        // Single write beat may cut into a read burst, but only once per read grant
        if (wr_last_i && !rd_last_i && !sel_q) begin
          sel = 1'b1;
        // Keep a burst going once it has started
        end else if (cont_q && sel_q && wr_active_i) begin
          sel = 1'b1;
        end else if (cont_q && !sel_q && rd_active_i) begin
          sel = 1'b0;
        end else begin
          sel = ~sel_q;
        end
      end
    end
  end

  assign grant     = mem_gnt_i & track_ready_i;
  assign win_valid = sel ? wr_valid_i : rd_valid_i;
  assign win_last  = sel ? wr_last_i : rd_last_i;

  assign rd_ready_o = ~sel & grant;
  assign wr_ready_o = sel & grant;

  // Memory and tracker take the beat in the same cycle
  assign mem_req_o     = win_valid & track_ready_i;
  assign track_valid_o = win_valid & mem_gnt_i;

  assign mem_addr_o    = sel ? wr_addr_i : rd_addr_i;
  assign mem_wdata_o   = wr_data_i;
  assign mem_strb_o    = wr_strb_i;
  assign mem_we_o      = sel;
  assign track_id_o    = sel ? wr_id_i : rd_id_i;
  assign track_last_o  = win_last;
  assign track_write_o = sel;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q  <= 1'b0;
      lock_q <= 1'b0;
      cont_q <= 1'b0;
    end else begin
      if (win_valid) begin
        sel_q <= sel;
      end
      lock_q <= win_valid & ~grant;
      if (win_valid && grant) begin
        cont_q <= ~win_last;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    win_valid && !grant |=> win_valid && (sel == $past(sel)))
    else $error("Arbiter choice changed while its beat was stalled");

endmodule

`default_nettype wire

// File: rtl/mem_to_banks.sv
// Bank splitter
// Spreads one full-width beat over the banks and gathers their responses

`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_settings.svh"

module mem_to_banks
  import axi_mem_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  req_i,
  output logic                                  gnt_o,
  input  addr_t                                 addr_i,
  input  data_t                                 wdata_i,
  input  strb_t                                 strb_i,
  input  logic                                  we_i,
  output logic                                  rvalid_o,
  input  logic                                  rready_i,
  output data_t                                 rdata_o,
  output logic       [`MEM_NUM_BANKS-1:0]       bank_req_o,
  input  logic       [`MEM_NUM_BANKS-1:0]       bank_gnt_i,
  output addr_t      [`MEM_NUM_BANKS-1:0]       bank_addr_o,
  output bank_data_t [`MEM_NUM_BANKS-1:0]       bank_wdata_o,
  output bank_strb_t [`MEM_NUM_BANKS-1:0]       bank_strb_o,
  output logic       [`MEM_NUM_BANKS-1:0]       bank_we_o,
  input  logic       [`MEM_NUM_BANKS-1:0]       bank_rvalid_i,
  input  bank_data_t [`MEM_NUM_BANKS-1:0]       bank_rdata_i
);

  localparam int unsigned NumBanks  = `MEM_NUM_BANKS;
  localparam int unsigned BankBits  = $bits(bank_data_t);
  localparam int unsigned BankBytes = $bits(bank_strb_t);

  // pend_q marks a granted bank access still waiting for its rvalid
  logic       [NumBanks-1:0] pend_q;
  logic       [NumBanks-1:0] rvld_q;
  bank_data_t [NumBanks-1:0] rdata_q;
  addr_t                     aligned;
  logic                      accept;

  assign aligned  = addr_i & ~(beat_bytes() - addr_t'(1));
  assign gnt_o    = ~|(bank_req_o | pend_q | rvld_q);
  assign accept   = req_i & gnt_o;
  assign rvalid_o = &rvld_q;
  assign rdata_o  = rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bank_req_o <= '0;
      pend_q     <= '0;
      rvld_q     <= '0;
    end else begin
      for (int i = 0; i < NumBanks; i++) begin
        if (accept) begin
          bank_req_o[i] <= 1'b1;
        end else if (bank_gnt_i[i]) begin
          bank_req_o[i] <= 1'b0;
        end
        if (bank_req_o[i] && bank_gnt_i[i]) begin
          pend_q[i] <= 1'b1;
        end else if (bank_rvalid_i[i]) begin
          pend_q[i] <= 1'b0;
        end
        if (bank_rvalid_i[i]) begin
          rvld_q[i] <= 1'b1;
        end else if (rvalid_o && rready_i) begin
          rvld_q[i] <= 1'b0;
        end
      end
    end
  end

  // Bank i sees the slice at byte offset i * BankBytes
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NumBanks; i++) begin
      if (accept) begin
        bank_addr_o[i]  <= aligned + addr_t'(i * BankBytes);
        bank_wdata_o[i] <= wdata_i[i*BankBits +: BankBits];
        bank_strb_o[i]  <= strb_i[i*BankBytes +: BankBytes];
        bank_we_o[i]    <= we_i;
      end
      if (bank_rvalid_i[i]) begin
        rdata_q[i] <= bank_rdata_i[i];
      end
    end
  end

  for (genvar g = 0; g < NumBanks; g++) begin : gen_req_check
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      bank_req_o[g] && !bank_gnt_i[g] |=>
        bank_req_o[g] && $stable(bank_addr_o[g]) && $stable(bank_we_o[g]))
      else $error("Bank request changed before its grant");
  end

endmodule

`default_nettype wire

// File: rtl/resp_tracker.sv
// Response tracker
// Beat information FIFO joined with memory responses, routed to R or B

`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_settings.svh"

module resp_tracker
  import axi_mem_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  track_valid_i,
  output logic  track_ready_o,
  input  id_t   track_id_i,
  input  logic  track_last_i,
  input  logic  track_write_i,
  input  logic  mem_rvalid_i,
  output logic  mem_rready_o,
  input  data_t mem_rdata_i,
  output logic  r_valid_o,
  input  logic  r_ready_i,
  output data_t r_data_o,
  output id_t   r_id_o,
  output logic  r_last_o,
  output logic  b_valid_o,
  input  logic  b_ready_i,
  output id_t   b_id_o,
  output logic  idle_o
);

  localparam int unsigned Depth    = `RESP_BUF_DEPTH;
  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  id_t                 id_mem    [Depth];
  logic                last_mem  [Depth];
  logic                write_mem [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                head_valid;
  logic                head_write;
  logic                head_last;
  logic                take;
  logic                push;
  logic                pop;

  function automatic logic [PtrWidth-1:0] ptr_incr(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + PtrWidth'(1);
  endfunction

  assign head_valid = (count_q != '0);
  assign head_write = write_mem[rd_ptr_q];
  assign head_last  = last_mem[rd_ptr_q];

  // Non-final write beats need no channel and drain at once
  assign take = head_write ? (~head_last | b_ready_i) : r_ready_i;

  assign track_ready_o = (count_q != CntWidth'(Depth));
  assign mem_rready_o  = head_valid & take;
  assign push          = track_valid_i & track_ready_o;
  assign pop           = mem_rvalid_i & mem_rready_o;
  assign idle_o        = ~head_valid;

  assign r_valid_o = mem_rvalid_i & head_valid & ~head_write;
  assign r_data_o  = mem_rdata_i;
  assign r_id_o    = id_mem[rd_ptr_q];
  assign r_last_o  = head_last;
  assign b_valid_o = mem_rvalid_i & head_valid & head_write & head_last;
  assign b_id_o    = id_mem[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_incr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_incr(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + CntWidth'(1);
      end else if (pop && !push) begin
        count_q <= count_q - CntWidth'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      id_mem[wr_ptr_q]    <= track_id_i;
      last_mem[wr_ptr_q]  <= track_last_i;
      write_mem[wr_ptr_q] <= track_write_i;
    end
  end

  // R data comes from the bank splitter, which must hold it while stalled
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_o && !r_ready_i |=>
      r_valid_o && $stable(r_data_o) && $stable(r_id_o) && $stable(r_last_o))
    else $error("R beat changed under back-pressure");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the AXI to memory bridge testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi_to_mem -Mdir obj_dir -o sim -f axi_to_mem.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "No errors"; then
  exit 0
fi
exit 1

// File: testbench/bank_mem_model.sv
// Behavioral memory banks for the bridge testbench
// Random grant delay, one-cycle response latency, byte strobes

`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_settings.svh"

module bank_mem_model
  import axi_mem_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic       [`MEM_NUM_BANKS-1:0] req_i,
  output logic       [`MEM_NUM_BANKS-1:0] gnt_o,
  input  addr_t      [`MEM_NUM_BANKS-1:0] addr_i,
  input  bank_data_t [`MEM_NUM_BANKS-1:0] wdata_i,
  input  bank_strb_t [`MEM_NUM_BANKS-1:0] strb_i,
  input  logic       [`MEM_NUM_BANKS-1:0] we_i,
  output logic       [`MEM_NUM_BANKS-1:0] rvalid_o,
  output bank_data_t [`MEM_NUM_BANKS-1:0] rdata_o
);

  localparam int unsigned NumBanks  = `MEM_NUM_BANKS;
  localparam int unsigned BankBytes = $bits(bank_strb_t);

  logic       [7:0]          storage [0:65535];
  logic       [31:0]         state;
  logic       [NumBanks-1:0] hit_q;
  bank_data_t [NumBanks-1:0] rd_q;

  function automatic logic [7:0] fill_byte(input logic [15:0] a);
    return (a[7:0] ^ a[15:8]) + 8'h3c;
  endfunction

  function logic [31:0] next_rand();
    state = state * 32'd1664525 + 32'd1013904223;
    return state;
  endfunction

  initial begin
    state = 32'hce55d488;
    for (int a = 0; a < 65536; a++) begin
      storage[a] = fill_byte(16'(a));
    end
  end

  // Access happens on the edge where request and grant meet
  always @(posedge clk_i) begin
    for (int i = 0; i < NumBanks; i++) begin
      hit_q[i] <= req_i[i] & gnt_o[i];
      if (req_i[i] && gnt_o[i]) begin
        for (int b = 0; b < BankBytes; b++) begin
          if (we_i[i]) begin
            if (strb_i[i][b]) begin
              storage[addr_t'(addr_i[i] + addr_t'(b))] = wdata_i[i][8*b +: 8];
            end
          end else begin
            rd_q[i][8*b +: 8] <= storage[addr_t'(addr_i[i] + addr_t'(b))];
          end
        end
      end
    end
  end

  always @(negedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_o    <= '0;
      rvalid_o <= '0;
      rdata_o  <= '0;
    end else begin
      rvalid_o <= hit_q;
      rdata_o  <= rd_q;
      // Grant about three times in four
      for (int i = 0; i < NumBanks; i++) begin
        gnt_o[i] <= req_i[i] & (next_rand() >= 32'h4000_0000);
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_axi_to_mem.sv
// Testbench for the AXI to banked memory bridge
// Directed and random bursts, shadow memory, assertion checking, timeout

`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_settings.svh"

module tb_axi_to_mem
  import axi_mem_pkg::*;
;

  logic clk_i, rst_ni, busy_o;
  logic aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, b_valid_o, b_ready_i;
  logic ar_valid_i, ar_ready_o, r_valid_o, r_ready_i, r_last_o;
  addr_t aw_addr_i, ar_addr_i;
  id_t aw_id_i, ar_id_i, b_id_o, r_id_o;
  len_t aw_len_i, ar_len_i;
  logic [1:0] aw_burst_i, ar_burst_i;
  data_t w_data_i, r_data_o;
  strb_t w_strb_i;
  logic [`MEM_NUM_BANKS-1:0] bank_req, bank_gnt, bank_we, bank_rvalid;
  addr_t [`MEM_NUM_BANKS-1:0] bank_addr;
  bank_data_t [`MEM_NUM_BANKS-1:0] bank_wdata, bank_rdata;
  bank_strb_t [`MEM_NUM_BANKS-1:0] bank_strb;

  logic [7:0] shadow [0:65535];
  data_t exp_r_data_q [$];
  id_t exp_r_id_q [$];
  logic exp_r_last_q [$];
  id_t exp_b_id_q [$];
  logic r_pend, exp_r_last, b_pend, end_check, rand_ready;
  data_t exp_r_data;
  id_t exp_r_id, exp_b_id;
  logic aw_hs, w_hs, ar_hs, r_hs, b_hs;
  logic [31:0] seed;
  int unsigned cycles, issued_beats;

  axi_to_mem DUT (
    .clk_i(clk_i), .rst_ni(rst_ni), .busy_o(busy_o),
    .aw_valid_i(aw_valid_i), .aw_ready_o(aw_ready_o), .aw_addr_i(aw_addr_i),
    .aw_id_i(aw_id_i), .aw_len_i(aw_len_i), .aw_burst_i(aw_burst_i),
    .w_valid_i(w_valid_i), .w_ready_o(w_ready_o), .w_data_i(w_data_i), .w_strb_i(w_strb_i),
    .b_valid_o(b_valid_o), .b_ready_i(b_ready_i), .b_id_o(b_id_o),
    .ar_valid_i(ar_valid_i), .ar_ready_o(ar_ready_o), .ar_addr_i(ar_addr_i),
    .ar_id_i(ar_id_i), .ar_len_i(ar_len_i), .ar_burst_i(ar_burst_i),
    .r_valid_o(r_valid_o), .r_ready_i(r_ready_i), .r_data_o(r_data_o),
    .r_id_o(r_id_o), .r_last_o(r_last_o),
    .bank_req_o(bank_req), .bank_gnt_i(bank_gnt), .bank_addr_o(bank_addr),
    .bank_wdata_o(bank_wdata), .bank_strb_o(bank_strb), .bank_we_o(bank_we),
    .bank_rvalid_i(bank_rvalid), .bank_rdata_i(bank_rdata)
  );

  bank_mem_model i_banks (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_i(bank_req), .gnt_o(bank_gnt),
    .addr_i(bank_addr), .wdata_i(bank_wdata), .strb_i(bank_strb), .we_i(bank_we),
    .rvalid_o(bank_rvalid), .rdata_o(bank_rdata)
  );

  always #10 clk_i = ~clk_i;

  function logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Same power-up pattern as the bank model
  function automatic logic [7:0] fill_byte(input logic [15:0] a);
    return (a[7:0] ^ a[15:8]) + 8'h3c;
  endfunction

  task automatic stop_sim();
    $display("Errors found");
    $fatal(1);
  endtask

  // Handshakes as seen at the clock edge
  always @(posedge clk_i) begin
    aw_hs  <= aw_valid_i & aw_ready_o;
    w_hs   <= w_valid_i & w_ready_o;
    ar_hs  <= ar_valid_i & ar_ready_o;
    r_hs   <= r_valid_o & r_ready_i;
    b_hs   <= b_valid_o & b_ready_i;
    cycles <= cycles + 1;
  end

  always @(posedge clk_i) begin
    if (cycles > 200 * issued_beats + 1000) begin
      $display("Timeout after %0d cycles with responses still missing", cycles);
      stop_sim();
    end
  end

  // Retire taken responses and present the next expected ones
  always @(negedge clk_i) begin
    if (r_hs && exp_r_data_q.size() != 0) begin
      void'(exp_r_data_q.pop_front());
      void'(exp_r_id_q.pop_front());
      void'(exp_r_last_q.pop_front());
    end
    if (b_hs && exp_b_id_q.size() != 0) begin
      void'(exp_b_id_q.pop_front());
    end
    r_pend = (exp_r_data_q.size() != 0);
    b_pend = (exp_b_id_q.size() != 0);
    if (r_pend) begin
      exp_r_data = exp_r_data_q[0];
      exp_r_id   = exp_r_id_q[0];
      exp_r_last = exp_r_last_q[0];
    end
    if (b_pend) begin
      exp_b_id = exp_b_id_q[0];
    end
  end

  always @(negedge clk_i) begin
    if (rand_ready) begin
      r_ready_i = next_rand() >= 32'h6000_0000;
      b_ready_i = next_rand() >= 32'h8000_0000;
    end else begin
      r_ready_i = 1'b1;
      b_ready_i = 1'b1;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) r_valid_o |-> r_pend)
    else begin
      $display("R beat arrived with no read outstanding");
      stop_sim();
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_o && r_pend |-> r_data_o == exp_r_data)
    else begin
      $display("error %0t: R data %h, expected %h", $time, r_data_o, exp_r_data);
      stop_sim();
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_o && r_pend |-> r_id_o == exp_r_id && r_last_o == exp_r_last)
    else begin
      $display("error %0t: R id %0d last %0d, expected id %0d last %0d",
               $time, r_id_o, r_last_o, exp_r_id, exp_r_last);
      stop_sim();
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni) b_valid_o |-> b_pend)
    else begin
      $display("B response arrived with no write outstanding");
      stop_sim();
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_valid_o && b_pend |-> b_id_o == exp_b_id)
    else begin
      $display("error %0t: B id %0d, expected %0d", $time, b_id_o, exp_b_id);
      stop_sim();
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni) end_check |-> !busy_o)
    else begin
      $display("error %0t: busy still high after all responses were taken", $time);
      stop_sim();
    end

  task automatic write_burst(input addr_t addr, input id_t id, input len_t len,
                             input bit partial);
    logic [31:0] r;
    data_t data;
    strb_t strb;
    addr_t a;
    exp_b_id_q.push_back(id);
    issued_beats += int'(len) + 1;
    aw_addr_i  = addr;
    aw_id_i    = id;
    aw_len_i   = len;
    aw_valid_i = 1'b1;
    @(negedge clk_i);
    while (!aw_hs) @(negedge clk_i);
    aw_valid_i = 1'b0;
    a = addr;
    for (int k = 0; k <= int'(len); k++) begin
      data = next_rand();
      r    = next_rand();
      strb = partial ? strb_t'(r) : '1;
      for (int b = 0; b < $bits(strb_t); b++) begin
        if (strb[b]) shadow[addr_t'(a + addr_t'(b))] = data[8*b +: 8];
      end
      w_data_i  = data;
      w_strb_i  = strb;
      w_valid_i = 1'b1;
      @(negedge clk_i);
      while (!w_hs) @(negedge clk_i);
      w_valid_i = 1'b0;
      a = a + addr_t'($bits(strb_t));
    end
  endtask

  task automatic read_burst(input addr_t addr, input id_t id, input len_t len);
    data_t d;
    addr_t a;
    a = addr;
    issued_beats += int'(len) + 1;
    for (int k = 0; k <= int'(len); k++) begin
      for (int b = 0; b < $bits(strb_t); b++) begin
        d[8*b +: 8] = shadow[addr_t'(a + addr_t'(b))];
      end
      exp_r_data_q.push_back(d);
      exp_r_id_q.push_back(id);
      exp_r_last_q.push_back(k == int'(len));
      a = a + addr_t'($bits(strb_t));
    end
    ar_addr_i  = addr;
    ar_id_i    = id;
    ar_len_i   = len;
    ar_valid_i = 1'b1;
    @(negedge clk_i);
    while (!ar_hs) @(negedge clk_i);
    ar_valid_i = 1'b0;
  endtask

  task automatic wait_responses();
    @(negedge clk_i);
    while (exp_r_data_q.size() != 0 || exp_b_id_q.size() != 0) @(negedge clk_i);
  endtask

  initial begin
    clk_i = 1'b0;
    rst_ni = 1'b0;
    seed = 32'hce55d488;
    {aw_valid_i, w_valid_i, ar_valid_i, r_ready_i, b_ready_i} = '0;
    {aw_addr_i, ar_addr_i, aw_id_i, ar_id_i, aw_len_i, ar_len_i} = '0;
    aw_burst_i = `AXI_BURST_INCR;
    ar_burst_i = `AXI_BURST_INCR;
    {w_data_i, w_strb_i} = '0;
    {r_pend, b_pend, end_check, rand_ready} = '0;
    issued_beats = 0;
    for (int a = 0; a < 65536; a++) shadow[a] = fill_byte(16'(a));
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    // Single beat write and read back
    write_burst(16'h0100, 4'd3, 8'd0, 1'b0);
    wait_responses();
    read_burst(16'h0100, 4'd5, 8'd0);
    wait_responses();
    // Strobed burst, then bursts over written and untouched words
    write_burst(16'h0200, 4'd6, 8'd7, 1'b1);
    wait_responses();
    read_burst(16'h0200, 4'd9, 8'd7);
    read_burst(16'h0300, 4'd2, 8'd4);
    wait_responses();

    // Mixed traffic on separate regions with random back-pressure
    rand_ready = 1'b1;
    fork
      repeat (12) write_burst(16'h1000 | addr_t'(next_rand() & 32'h0ffc),
                              id_t'(next_rand()), len_t'(next_rand() % 8), 1'b1);
      repeat (12) read_burst(16'h8000 | addr_t'(next_rand() & 32'h0ffc),
                             id_t'(next_rand()), len_t'(next_rand() % 8));
    join
    wait_responses();
    rand_ready = 1'b0;
    repeat (6) read_burst(16'h1000 | addr_t'(next_rand() & 32'h0ffc),
                          id_t'(next_rand()), len_t'(next_rand() % 8));
    wait_responses();

    repeat (4) @(negedge clk_i);
    end_check = 1'b1;
    repeat (3) @(negedge clk_i);
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire
